//--- Makefile
TOP = tb_alu_exec

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o vsim
	./obj_dir/vsim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- alu_checker.sv
`timescale 1ns/1ps
// Result checker
// Holds one expected result per tag and compares every result beat

module alu_checker (
    input logic              clk,
    input logic              arst_n,
    input logic              res_valid,
    input alu_pkg::alu_res_t res
);

    logic              pend [16];
    string             names [16];
    alu_pkg::alu_res_t expv [16];
    int                errors  = 0;
    int                checked = 0;
    int                pending = 0;  // Expected but not yet seen

    initial begin
        for (int i = 0; i < 16; i++) pend[i] = 1'b0;
    end

    task automatic expect_result(input logic [3:0] tag, input string name,
                                 input alu_pkg::alu_res_t e);
        if (pend[tag]) begin
            $display("Tag %0d reused before its result arrived", tag);
            errors++;
        end else begin
            pending++;
        end
        pend[tag]  = 1'b1;
        names[tag] = name;
        expv[tag]  = e;
    endtask

    always @(posedge clk) begin
        if (arst_n && res_valid) begin
            if (!pend[res.tag]) begin
                $display("Result with tag %0d was not expected or arrived twice", res.tag);
                errors++;
            end else begin
                if (res.rslt !== expv[res.tag].rslt) begin
                    $display("FAIL %s rslt expected %h actual %h", names[res.tag],
                             expv[res.tag].rslt, res.rslt);
                    errors++;
                end
                if (res.cc_out !== expv[res.tag].cc_out) begin
                    $display("FAIL %s cc expected %h actual %h", names[res.tag],
                             expv[res.tag].cc_out, res.cc_out);
                    errors++;
                end
                pend[res.tag] = 1'b0;
                pending--;
                checked++;
            end
        end
    end

endmodule

//--- alu_cmd_queue.sv
`timescale 1ns/1ps
// Command queue
// Holds incoming commands under credit flow control and dispatches
// them in order to the ALU or the divider

module alu_cmd_queue #(
    parameter int CMD_CREDITS = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  alu_pkg::alu_cmd_t cmd,
    output logic              cmd_credit,
    input  logic              alu_free,
    input  logic              div_free,
    output logic              alu_go,
    output logic              div_go,
    output alu_pkg::alu_cmd_t unit_cmd
);

    localparam int AW = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
    localparam int CW = $clog2(CMD_CREDITS + 1);

    alu_pkg::alu_cmd_t mem [CMD_CREDITS];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [CW-1:0]     count;
    logic              head_div;
    logic              pop;

    // Pointer advance with wrap at the queue depth
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(CMD_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign unit_cmd = mem[rd_ptr];                         // Head of queue
    assign head_div = (unit_cmd.op == alu_pkg::op_div);
    assign pop      = (count != '0) && (head_div ? div_free : alu_free);
    assign alu_go   = pop && !head_div;
    assign div_go   = pop && head_div;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count      <= count + CW'(cmd_valid) - CW'(pop);
            cmd_credit <= pop;                             // One credit back per removal
        end
    end

    // Entry storage, written on each accepted command
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

endmodule

//--- alu_core.sv
`timescale 1ns/1ps
// Single-cycle ALU
// Computes result and condition codes from the dispatched command and
// holds them until the result arbiter takes them

module alu_core (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alu_go,
    input  alu_pkg::alu_cmd_t unit_cmd,
    output logic              alu_free,
    output logic              alu_req,
    input  logic              alu_gnt,
    output alu_pkg::alu_res_t alu_res
);

    logic [15:0]       a;
    logic [15:0]       b;
    logic [15:0]       r;
    logic [15:0]       rf;
    logic [16:0]       ext;
    logic [7:0]        adj;
    logic [7:0]        cc_nx;
    logic              wide;
    logic              cin;
    logic              sa;
    logic              sb;
    logic              c_o;
    logic              v_o;
    logic              h_o;
    logic              n_upd;
    logic              hold_vld;
    alu_pkg::alu_res_t hold_res;

    function automatic logic [15:0] fit(input logic [15:0] v, input logic w);
        return w ? v : {8'h00, v[7:0]};
    endfunction

    function automatic logic top_bit(input logic [15:0] v, input logic w);
        return w ? v[15] : v[7];
    endfunction

    function automatic logic carry_bit(input logic [16:0] v, input logic w);
        return w ? v[16] : v[8];
    endfunction

    // SEX and MUL are always 16-bit, DAA always 8-bit
    assign wide = (unit_cmd.op == alu_pkg::op_sex || unit_cmd.op == alu_pkg::op_mul) ? 1'b1 :
                  (unit_cmd.op == alu_pkg::op_daa) ? 1'b0 : unit_cmd.w16;
    assign a    = fit(unit_cmd.opnd0, wide);
    assign b    = fit(unit_cmd.opnd1, wide);
    assign cin  = unit_cmd.cc_in[alu_pkg::cc_c];
    assign sa   = top_bit(a, wide);
    assign sb   = top_bit(b, wide);

    always_comb begin
        ext   = 17'd0;
        adj   = 8'h00;
        r     = a;
        c_o   = cin;
        v_o   = unit_cmd.cc_in[alu_pkg::cc_v];
        h_o   = unit_cmd.cc_in[alu_pkg::cc_h];
        n_upd = 1'b1;
        case (unit_cmd.op)
            alu_pkg::op_ld: v_o = 1'b0;
            alu_pkg::op_add, alu_pkg::op_adc: begin
                ext = {1'b0, a} + {1'b0, b} + 17'(cin && unit_cmd.op == alu_pkg::op_adc);
                r   = ext[15:0];
                c_o = carry_bit(ext, wide);
                v_o = (sa == sb) && (top_bit(r, wide) != sa);
                if (!wide) begin
                    h_o = a[4] ^ b[4] ^ r[4];              // Half carry, 8-bit only
                end
            end
            alu_pkg::op_sub, alu_pkg::op_sbc, alu_pkg::op_cmp: begin
                ext = {1'b0, a} - {1'b0, b} - 17'(cin && unit_cmd.op == alu_pkg::op_sbc);
                r   = ext[15:0];
                c_o = carry_bit(ext, wide);                // Borrow
                v_o = (sa != sb) && (top_bit(r, wide) != sa);
            end
            alu_pkg::op_and: begin
                r   = a & b;
                v_o = 1'b0;
            end
            alu_pkg::op_eor: begin
                r   = a ^ b;
                v_o = 1'b0;
            end
            alu_pkg::op_or: begin
                r   = a | b;
                v_o = 1'b0;
            end
            alu_pkg::op_clr: begin
                r   = 16'h0000;
                c_o = 1'b0;
                v_o = 1'b0;
            end
            alu_pkg::op_com: begin
                r   = ~a;
                c_o = 1'b1;
                v_o = 1'b0;
            end
            alu_pkg::op_neg: begin
                ext = 17'd0 - {1'b0, a};
                r   = ext[15:0];
                c_o = carry_bit(ext, wide);                // Set unless operand is zero
                v_o = sa & top_bit(r, wide);               // Only for the most negative value
            end
            alu_pkg::op_inc: begin
                r   = a + 16'd1;
                v_o = !sa && top_bit(r, wide);
            end
            alu_pkg::op_dec: begin
                r   = a - 16'd1;
                v_o = sa && !top_bit(r, wide);
            end
            alu_pkg::op_lsr: begin
                r   = a >> 1;
                c_o = a[0];
            end
            alu_pkg::op_asr: begin
                r   = wide ? {a[15], a[15:1]} : {8'h00, a[7], a[7:1]};
                c_o = a[0];
            end
            alu_pkg::op_asl: begin
                r   = a << 1;
                c_o = sa;
                v_o = sa ^ top_bit(r, wide);
            end
            alu_pkg::op_ror: begin
                r   = wide ? {cin, a[15:1]} : {8'h00, cin, a[7:1]};
                c_o = a[0];
            end
            alu_pkg::op_rol: begin
                r   = {a[14:0], cin};
                c_o = sa;
                v_o = sa ^ top_bit(r, wide);
            end
            alu_pkg::op_sex: begin
                r   = {{8{a[7]}}, a[7:0]};
                v_o = 1'b0;
            end
            alu_pkg::op_abs: begin
                r   = sa ? 16'h0000 - a : a;
                c_o = 1'b0;
                v_o = 1'b0;
            end
            alu_pkg::op_mul: begin
                r     = {8'h00, a[15:8]} * {8'h00, a[7:0]};
                c_o   = r[7];
                n_upd = 1'b0;                              // N untouched by MUL
            end
            alu_pkg::op_daa: begin
                if (cin || a[7:4] > 4'h9 || (a[7:4] > 4'h8 && a[3:0] > 4'h9)) begin
                    adj[7:4] = 4'h6;
                end
                if (unit_cmd.cc_in[alu_pkg::cc_h] || a[3:0] > 4'h9) begin
                    adj[3:0] = 4'h6;
                end
                ext = {9'd0, a[7:0]} + {9'd0, adj};
                r   = ext[15:0];
                c_o = cin | ext[8];                        // Carry is sticky
                v_o = 1'b0;
            end
            default: r = a;
        endcase

        // Z and N at the effective width, E I F pass through
        rf                    = fit(r, wide);
        cc_nx                 = unit_cmd.cc_in;
        cc_nx[alu_pkg::cc_c]  = c_o;
        cc_nx[alu_pkg::cc_v]  = v_o;
        cc_nx[alu_pkg::cc_h]  = h_o;
        cc_nx[alu_pkg::cc_z]  = (rf == 16'h0000);
        if (n_upd) begin
            cc_nx[alu_pkg::cc_n] = top_bit(rf, wide);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_vld <= 1'b0;
        end else if (alu_go) begin
            hold_vld <= 1'b1;
        end else if (alu_gnt) begin
            hold_vld <= 1'b0;                              // Free from next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (alu_go) begin
            hold_res.tag    <= unit_cmd.tag;
            hold_res.rslt   <= rf;
            hold_res.cc_out <= cc_nx;
        end
    end

    assign alu_free = !hold_vld;
    assign alu_req  = hold_vld;
    assign alu_res  = hold_res;

endmodule

//--- alu_div.sv
`timescale 1ns/1ps
// 16/8 unsigned divider
// Restoring shift-subtract over 16 cycles, remainder in the high byte
// and quotient in the low byte of the result

module alu_div (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              div_go,
    input  alu_pkg::alu_cmd_t unit_cmd,
    output logic              div_free,
    output logic              div_req,
    input  logic              div_gnt,
    output alu_pkg::alu_res_t div_res
);

    alu_pkg::div_state_e state;
    logic [3:0]          cnt;
    logic [7:0]          dvs;
    logic [7:0]          rem;
    logic [15:0]         quo;
    logic [9:0]          trial;
    logic [3:0]          tag;
    logic [7:0]          cc_keep;
    logic                ovf;
    logic                bad;

    // Zero divisor or quotient wider than a byte
    assign bad   = (unit_cmd.opnd1[7:0] == 8'h00) ||
                   (unit_cmd.opnd0[15:8] >= unit_cmd.opnd1[7:0]);
    assign trial = {1'b0, rem, quo[15]} - {2'b00, dvs};   // Borrow in bit 9

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= alu_pkg::idle;
            cnt   <= 4'd0;
        end else begin
            case (state)
                alu_pkg::idle: if (div_go) begin
                    state <= bad ? alu_pkg::done : alu_pkg::run;
                    cnt   <= 4'd0;
                end
                alu_pkg::run: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd15) begin
                        state <= alu_pkg::done;
                    end
                end
                alu_pkg::done: if (div_gnt) state <= alu_pkg::idle;
                default: state <= alu_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_pkg::idle && div_go) begin
            dvs     <= unit_cmd.opnd1[7:0];
            tag     <= unit_cmd.tag;
            cc_keep <= unit_cmd.cc_in;
            ovf     <= bad;
            rem     <= bad ? unit_cmd.opnd0[15:8] : 8'h00; // Overflow returns opnd0 as is
            quo     <= unit_cmd.opnd0;
        end else if (state == alu_pkg::run) begin
            rem <= trial[9] ? {rem[6:0], quo[15]} : trial[7:0];
            quo <= {quo[14:0], ~trial[9]};
        end
    end

    always_comb begin
        div_res.tag                 = tag;
        div_res.rslt                = {rem, quo[7:0]};
        div_res.cc_out              = cc_keep;
        div_res.cc_out[alu_pkg::cc_c] = 1'b0;
        div_res.cc_out[alu_pkg::cc_v] = ovf;
        div_res.cc_out[alu_pkg::cc_z] = (quo[7:0] == 8'h00);
    end

    assign div_free = (state == alu_pkg::idle);
    assign div_req  = (state == alu_pkg::done);

endmodule

//--- alu_exec_asserts.sv
`timescale 1ns/1ps
// Protocol assertions for the execution block
// Result credits, exclusive grants and command credit accounting

module alu_exec_asserts #(
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic arst_n,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic res_valid,
    input logic res_credit,
    input logic alu_gnt,
    input logic div_gnt
);

    int res_held;   // Results out and not yet credited
    int cmd_acc;
    int cmd_ret;
    int fails = 0;  // Assertion failures so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_held <= 0;
            cmd_acc  <= 0;
            cmd_ret  <= 0;
        end else begin
            res_held <= res_held + int'(res_valid) - int'(res_credit);
            cmd_acc  <= cmd_acc + int'(cmd_valid);
            cmd_ret  <= cmd_ret + int'(cmd_credit);
        end
    end

    res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> res_held < RES_CREDITS)
        else begin
            $error("Result sent with no result credit left");
            fails++;
        end

    one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        !(alu_gnt && div_gnt))
        else begin
            $error("Both units granted in one cycle");
            fails++;
        end

    credit_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_credit |-> cmd_ret < cmd_acc)
        else begin
            $error("More command credits returned than commands accepted");
            fails++;
        end

endmodule

//--- alu_exec_top.sv
`timescale 1ns/1ps
// ALU execution block
// Command queue feeding the ALU and divider, results merged by the arbiter

module alu_exec_top #(
    parameter int CMD_CREDITS = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  alu_pkg::alu_cmd_t cmd,
    output logic              cmd_credit,
    output logic              res_valid,
    output alu_pkg::alu_res_t res,
    input  logic              res_credit
);

    logic              alu_free;
    logic              div_free;
    logic              alu_go;
    logic              div_go;
    logic              alu_req;
    logic              div_req;
    logic              alu_gnt;
    logic              div_gnt;
    alu_pkg::alu_cmd_t unit_cmd;
    alu_pkg::alu_res_t alu_res;
    alu_pkg::alu_res_t div_res;

    alu_cmd_queue #(.CMD_CREDITS(CMD_CREDITS)) u_queue (
        .clk, .arst_n, .cmd_valid, .cmd, .cmd_credit,
        .alu_free, .div_free, .alu_go, .div_go, .unit_cmd
    );

    alu_core u_core (
        .clk, .arst_n, .alu_go, .unit_cmd, .alu_free, .alu_req, .alu_gnt, .alu_res
    );

    alu_div u_div (
        .clk, .arst_n, .div_go, .unit_cmd, .div_free, .div_req, .div_gnt, .div_res
    );

    alu_result_arb #(.RES_CREDITS(RES_CREDITS)) u_arb (
        .clk, .arst_n, .alu_req, .alu_res, .div_req, .div_res,
        .alu_gnt, .div_gnt, .res_valid, .res, .res_credit
    );

endmodule

//--- alu_pkg.sv
// ALU execution package
// Opcodes, condition-code bit positions, command and result structs
// and the divider states shared by the execution units

package alu_pkg;

    // ALU and divider opcodes
    typedef enum logic [4:0] {
        op_ld  = 5'd0,   // Load or test, result is opnd0
        op_add = 5'd1,
        op_adc = 5'd2,
        op_sub = 5'd3,
        op_sbc = 5'd4,
        op_cmp = 5'd5,   // Subtract, difference is returned
        op_and = 5'd6,
        op_eor = 5'd7,
        op_or  = 5'd8,
        op_clr = 5'd9,
        op_com = 5'd10,
        op_neg = 5'd11,
        op_inc = 5'd12,
        op_dec = 5'd13,
        op_lsr = 5'd14,
        op_asr = 5'd15,
        op_asl = 5'd16,
        op_ror = 5'd17,
        op_rol = 5'd18,
        op_sex = 5'd19,  // Always 16-bit result
        op_abs = 5'd20,
        op_mul = 5'd21,  // Bytes of opnd0 multiplied
        op_daa = 5'd22,  // Always 8-bit
        op_div = 5'd23   // Goes to the divider
    } alu_op_e;

    // Condition code bit positions, 6809 layout
    localparam int cc_c = 0;  // Carry or borrow
    localparam int cc_v = 1;  // Overflow
    localparam int cc_z = 2;  // Zero
    localparam int cc_n = 3;  // Negative
    localparam int cc_i = 4;  // IRQ mask
    localparam int cc_h = 5;  // Half carry
    localparam int cc_f = 6;  // FIRQ mask
    localparam int cc_e = 7;  // Entire state

    // Command into the execution block, 50 bits
    typedef struct packed {
        alu_op_e     op;
        logic        w16;    // 16-bit operation
        logic [3:0]  tag;
        logic [15:0] opnd0;
        logic [15:0] opnd1;
        logic [7:0]  cc_in;
    } alu_cmd_t;

    // Tagged result, 28 bits
    typedef struct packed {
        logic [3:0]  tag;
        logic [15:0] rslt;
        logic [7:0]  cc_out;
    } alu_res_t;

    // Divider FSM
    typedef enum logic [1:0] {
        idle = 2'd0,
        run  = 2'd1,
        done = 2'd2
    } div_state_e;

endpackage

//--- alu_result_arb.sv
`timescale 1ns/1ps
// Result arbiter
// Round-robin between ALU and divider, one grant per cycle, and only
// while a result credit is held

module alu_result_arb #(
    parameter int RES_CREDITS = 2
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alu_req,
    input  alu_pkg::alu_res_t alu_res,
    input  logic              div_req,
    input  alu_pkg::alu_res_t div_res,
    output logic              alu_gnt,
    output logic              div_gnt,
    output logic              res_valid,
    output alu_pkg::alu_res_t res,
    input  logic              res_credit
);

    localparam int CW = $clog2(RES_CREDITS + 1);

    logic [CW-1:0] credits;
    logic          have_credit;
    logic          div_first;    // Divider has priority next
    logic          any_gnt;

    assign have_credit = (credits != '0);
    assign alu_gnt     = have_credit && alu_req && (!div_req || !div_first);
    assign div_gnt     = have_credit && div_req && (!alu_req || div_first);
    assign any_gnt     = alu_gnt || div_gnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= CW'(RES_CREDITS);
            div_first <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= any_gnt;
            credits   <= credits - CW'(any_gnt) + CW'(res_credit);
            if (alu_gnt) begin
                div_first <= 1'b1;
            end else if (div_gnt) begin
                div_first <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu_gnt) begin
            res <= alu_res;
        end else if (div_gnt) begin
            res <= div_res;
        end
    end

endmodule

//--- sources.f
alu_pkg.sv
alu_cmd_queue.sv
alu_core.sv
alu_div.sv
alu_result_arb.sv
alu_exec_top.sv
alu_checker.sv
alu_exec_asserts.sv
tb_alu_exec.sv

//--- tb_alu_exec.sv
`timescale 1ns/1ps
// Testbench for the ALU execution block
// Applies a table of commands under credit flow control, returns result
// credits with random gaps and hands expected results to the checker

module tb_alu_exec;

    localparam int CMD_CREDITS = 4;
    localparam int RES_CREDITS = 2;
    localparam int TIMEOUT     = 2000;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              cmd_valid;
    alu_pkg::alu_cmd_t cmd;
    logic              cmd_credit;
    logic              res_valid;
    alu_pkg::alu_res_t res;
    logic              res_credit;

    string             row_name[$];     // Stimulus table
    alu_pkg::alu_cmd_t row_cmd[$];
    int                split;           // First row of the ordering group
    int                sent       = 0;
    int                cmd_back   = 0;
    int                res_seen   = 0;
    int                res_back   = 0;
    int                errors     = 0;
    bit                starve     = 1'b0;
    logic [31:0]       seed_stim  = 32'h8e6c_bb4b;
    logic [31:0]       seed_cred  = 32'h8e6c_bb4b;

    alu_exec_top #(.CMD_CREDITS(CMD_CREDITS), .RES_CREDITS(RES_CREDITS)) u_dut (
        .clk, .arst_n, .cmd_valid, .cmd, .cmd_credit, .res_valid, .res, .res_credit
    );

    alu_checker u_chk (.clk, .arst_n, .res_valid, .res);

    bind alu_exec_top alu_exec_asserts #(.RES_CREDITS(RES_CREDITS)) u_asserts (
        .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_credit(cmd_credit),
        .res_valid(res_valid), .res_credit(res_credit), .alu_gnt(alu_gnt), .div_gnt(div_gnt)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg(inout logic [31:0] s);
        s = s * 32'd1664525 + 32'd1013904223;
        return s;
    endfunction

    // Expected result from the instruction set rules
    function automatic alu_pkg::alu_res_t model(input alu_pkg::alu_cmd_t c);
        int unsigned       msk;
        int unsigned       sgn;
        int unsigned       a;
        int unsigned       b;
        int unsigned       r;
        int unsigned       full;
        int unsigned       adj;
        logic [7:0]        cc;
        bit                wide;
        bit                cy;
        bit                upd_n;
        alu_pkg::alu_res_t o;
        cc    = c.cc_in;
        cy    = cc[alu_pkg::cc_c];
        upd_n = 1'b1;
        o.tag = c.tag;
        if (c.op == alu_pkg::op_div) begin
            b = c.opnd1[7:0];
            if (b == 0 || c.opnd0[15:8] >= b) begin
                r                = c.opnd0;
                cc[alu_pkg::cc_v] = 1'b1;
            end else begin
                r                = ((c.opnd0 % b) << 8) | (c.opnd0 / b);
                cc[alu_pkg::cc_v] = 1'b0;
            end
            cc[alu_pkg::cc_c] = 1'b0;
            cc[alu_pkg::cc_z] = (r & 32'hff) == 0;
            o.rslt   = 16'(r);
            o.cc_out = cc;
            return o;
        end
        wide = (c.op == alu_pkg::op_sex || c.op == alu_pkg::op_mul) ? 1'b1 :
               (c.op == alu_pkg::op_daa) ? 1'b0 : c.w16;
        msk  = wide ? 32'hffff : 32'hff;
        sgn  = wide ? 32'h8000 : 32'h80;
        a    = c.opnd0 & msk;
        b    = c.opnd1 & msk;
        r    = a;
        case (c.op)
            alu_pkg::op_add, alu_pkg::op_adc: begin
                full = a + b + ((c.op == alu_pkg::op_adc && cy) ? 1 : 0);
                r    = full & msk;
                cc[alu_pkg::cc_c] = full > msk;
                cc[alu_pkg::cc_v] = (~(a ^ b) & (a ^ r) & sgn) != 0;
                if (!wide) cc[alu_pkg::cc_h] = ((a ^ b ^ full) & 32'h10) != 0;
            end
            alu_pkg::op_sub, alu_pkg::op_sbc, alu_pkg::op_cmp: begin
                full = b + ((c.op == alu_pkg::op_sbc && cy) ? 1 : 0);
                r    = (a - full) & msk;
                cc[alu_pkg::cc_c] = a < full;       // Borrow
                cc[alu_pkg::cc_v] = ((a ^ b) & (a ^ r) & sgn) != 0;
            end
            alu_pkg::op_ld:  cc[alu_pkg::cc_v] = 1'b0;
            alu_pkg::op_and: begin
                r = a & b;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_eor: begin
                r = a ^ b;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_or: begin
                r = a | b;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_clr: begin
                r = 0;
                cc[alu_pkg::cc_c] = 1'b0;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_com: begin
                r = ~a & msk;
                cc[alu_pkg::cc_c] = 1'b1;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_neg: begin
                r = (0 - a) & msk;
                cc[alu_pkg::cc_c] = a != 0;
                cc[alu_pkg::cc_v] = a == sgn;
            end
            alu_pkg::op_inc: begin
                r = (a + 1) & msk;
                cc[alu_pkg::cc_v] = a == sgn - 1;
            end
            alu_pkg::op_dec: begin
                r = (a - 1) & msk;
                cc[alu_pkg::cc_v] = a == sgn;
            end
            alu_pkg::op_lsr: begin
                r = a >> 1;
                cc[alu_pkg::cc_c] = a[0];
            end
            alu_pkg::op_asr: begin
                r = (a >> 1) | (a & sgn);
                cc[alu_pkg::cc_c] = a[0];
            end
            alu_pkg::op_ror: begin
                r = (a >> 1) | (cy ? sgn : 0);
                cc[alu_pkg::cc_c] = a[0];
            end
            alu_pkg::op_asl, alu_pkg::op_rol: begin
                r = ((a << 1) | ((c.op == alu_pkg::op_rol && cy) ? 1 : 0)) & msk;
                cc[alu_pkg::cc_c] = (a & sgn) != 0;
                cc[alu_pkg::cc_v] = ((a ^ (a << 1)) & sgn) != 0;
            end
            alu_pkg::op_sex: begin
                r = a[7] ? (a | 32'hff00) : (a & 32'hff);
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_abs: begin
                r = (a & sgn) ? ((0 - a) & msk) : a;
                cc[alu_pkg::cc_c] = 1'b0;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            alu_pkg::op_mul: begin
                r     = (a >> 8) * (a & 32'hff);
                upd_n = 1'b0;
                cc[alu_pkg::cc_c] = r[7];
            end
            alu_pkg::op_daa: begin
                adj = 0;
                if (cy || (a >> 4) > 9 || ((a >> 4) > 8 && (a & 15) > 9)) adj = 32'h60;
                if (cc[alu_pkg::cc_h] || (a & 15) > 9) adj = adj | 32'h06;
                full = a + adj;
                r    = full & 32'hff;
                cc[alu_pkg::cc_c] = cy || full > 32'hff;
                cc[alu_pkg::cc_v] = 1'b0;
            end
            default: r = a;
        endcase
        cc[alu_pkg::cc_z] = r == 0;
        if (upd_n) cc[alu_pkg::cc_n] = (r & sgn) != 0;
        o.rslt   = 16'(r);
        o.cc_out = cc;
        return o;
    endfunction

    task automatic row(input string name, input alu_pkg::alu_op_e op, input logic w16,
                       input logic [15:0] a, input logic [15:0] b, input logic [7:0] cc);
        alu_pkg::alu_cmd_t c;
        c = '{op: op, w16: w16, tag: 4'h0, opnd0: a, opnd1: b, cc_in: cc};
        row_name.push_back(name);
        row_cmd.push_back(c);
    endtask

    task automatic finish_run();
        int total;
        total = errors + u_chk.errors + u_dut.u_asserts.fails;
        $display("Results checked %0d, errors %0d, missing %0d", u_chk.checked,
                 total, u_chk.pending);
        if (total + u_chk.pending == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic send_row(input int i);
        alu_pkg::alu_cmd_t c;
        int                n;
        c     = row_cmd[i];
        c.tag = 4'(i % 16);
        u_chk.expect_result(c.tag, row_name[i], model(c));
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) timed_out("a command credit");
        end while (CMD_CREDITS - sent + cmd_back == 0);
        cmd_valid <= 1'b1;
        cmd       <= c;
        sent++;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (res_seen != sent || res_seen != res_back) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) timed_out("outstanding results to drain");
        end
    endtask

    always @(posedge clk) begin
        if (cmd_credit) cmd_back <= cmd_back + 1;
        if (res_valid) begin
            res_seen <= res_seen + 1;
            if (res_seen - res_back >= RES_CREDITS) begin
                $display("Result seen without a result credit");
                errors++;
            end
        end
    end

    // Credit return with 0 to 3 cycles of delay
    initial begin : credit_return
        int gap;
        res_credit = 1'b0;
        forever begin
            @(posedge clk);
            res_credit <= 1'b0;
            if (res_seen > res_back && !starve) begin
                gap = int'(lcg(seed_cred) >> 12) % 4;
                repeat (gap) @(posedge clk);
                res_credit <= 1'b1;
                res_back   <= res_back + 1;
            end
        end
    end

    initial begin : stimulus
        int                n;
        alu_pkg::alu_op_e  op_k;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        row("add8 half", alu_pkg::op_add, 1'b0, 16'h0008, 16'h0008, 8'h00);
        row("add8 ovf", alu_pkg::op_add, 1'b0, 16'h007f, 16'h0001, 8'h00);
        row("adc16 carry", alu_pkg::op_adc, 1'b1, 16'hffff, 16'h0000, 8'h01);
        row("sub8 borrow", alu_pkg::op_sub, 1'b0, 16'h0000, 16'h0001, 8'hd0);
        row("neg8 min", alu_pkg::op_neg, 1'b0, 16'h0080, 16'h0000, 8'h00);
        row("neg16 zero", alu_pkg::op_neg, 1'b1, 16'h0000, 16'h0000, 8'h00);
        row("daa carry", alu_pkg::op_daa, 1'b0, 16'h009a, 16'h0000, 8'h00);
        row("daa half", alu_pkg::op_daa, 1'b0, 16'h0012, 16'h0000, 8'h20);
        row("mul ff", alu_pkg::op_mul, 1'b0, 16'hffff, 16'h0000, 8'h00);
        row("sex neg", alu_pkg::op_sex, 1'b0, 16'h0080, 16'h0000, 8'h00);
        row("div basic", alu_pkg::op_div, 1'b0, 16'h0064, 16'h0007, 8'h00);
        row("div zero", alu_pkg::op_div, 1'b0, 16'h1234, 16'h0000, 8'h00);
        row("div ovf", alu_pkg::op_div, 1'b0, 16'h2000, 16'h0010, 8'hc0);
        for (int k = 0; k < 23; k++) begin      // Every ALU op, both widths and carries
            op_k = alu_pkg::alu_op_e'(k);
            for (int w = 0; w < 2; w++) begin
                for (int ci = 0; ci < 2; ci++) begin
                    row($sformatf("%s w%0d c%0d", op_k.name(), w, ci),
                        op_k, w[0], 16'(lcg(seed_stim) >> 8),
                        16'(lcg(seed_stim) >> 8), 8'((lcg(seed_stim) >> 8) & 32'hfe) | 8'(ci));
                end
            end
        end
        for (int k = 0; k < 8; k++) begin
            row($sformatf("div rnd %0d", k), alu_pkg::op_div, 1'b0,
                16'(lcg(seed_stim) >> 12), 16'(lcg(seed_stim) >> 8), 8'(lcg(seed_stim) >> 8));
        end
        split = row_name.size();
        row("order div", alu_pkg::op_div, 1'b0, 16'h0f3c, 16'h0041, 8'h00);
        row("order add", alu_pkg::op_add, 1'b1, 16'h1234, 16'h4321, 8'h00);
        row("order and", alu_pkg::op_and, 1'b0, 16'h00f0, 16'h003c, 8'h00);
        row("order asl", alu_pkg::op_asl, 1'b0, 16'h00c1, 16'h0000, 8'h00);

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < split; i++) send_row(i);
        drain();
        starve <= 1'b1;                         // Hold result credits back
        for (int i = split; i < row_name.size(); i++) send_row(i);
        repeat (40) @(posedge clk);
        starve <= 1'b0;
        drain();
        n = 0;
        while (CMD_CREDITS - sent + cmd_back != CMD_CREDITS) begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) timed_out("all command credits to return");
        end
        if (res_seen != sent) begin
            $display("Sent %0d commands but saw %0d results", sent, res_seen);
            errors++;
        end
        finish_run();
    end

endmodule
